// File: design/decor_unit.sv
`timescale 1ns/1ns
`default_nettype none

module decor_unit (
    input  wire                          clk_fastica,
    input  wire                          go_fastica,
    input  wire                          start,
    input  wire                          go_symm,
    input  wire                          en_norm,
    input  wire fastica_pkg::weight_mat_t w_new,
    input  wire                          wnew_valid,
    output fastica_pkg::weight_mat_t      w,
    output logic                         symm_busy
);
    import fastica_pkg::*;

    logic go_symm_d;
    logic phase;
    acc_t d_q;
    acc_t e_q;
    acc_t m0;
    acc_t m1;

    // removes the row 0 component from one row 1 element
    function automatic coef_t orth_el(coef_t v, coef_t v0, acc_t d, acc_t e);
        logic signed [63:0] prod;
        prod = 64'(d) * 64'(v0);
        if (e == 0) begin
            return v;
        end
        return sat_coef(acc_t'(v) - acc_t'(prod / e));
    endfunction

    function automatic coef_t norm_el(coef_t v, acc_t m);
        if (m == 0) begin
            return v;
        end
        return sat_coef((acc_t'(v) <<< frac_bits) / m);
    endfunction

    // larger element magnitude of each row
    assign m0 = (abs_acc(w.w00) > abs_acc(w.w01)) ? abs_acc(w.w00) : abs_acc(w.w01);
    assign m1 = (abs_acc(w.w10) > abs_acc(w.w11)) ? abs_acc(w.w10) : abs_acc(w.w11);

    // busy in the rising cycle of go_symm and the one after
    assign symm_busy = (go_symm & ~go_symm_d) | phase;

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            go_symm_d <= 1'b0;
            phase     <= 1'b0;
        end else begin
            go_symm_d <= go_symm;
            phase     <= symm_busy & ~phase;
        end
    end

    always_ff @(posedge clk_fastica) begin
        if (symm_busy && !phase) begin
            d_q <= acc_t'(w.w00) * w.w10 + acc_t'(w.w01) * w.w11;
            e_q <= acc_t'(w.w00) * w.w00 + acc_t'(w.w01) * w.w01;
        end
        if (start) begin
            w <= '{w00: coef_t'(1 <<< frac_bits), w01: '0,
                   w10: '0, w11: coef_t'(1 <<< frac_bits)};
        end else if (wnew_valid) begin
            w <= w_new;
        end else if (phase) begin
            w.w10 <= orth_el(w.w10, w.w00, d_q, e_q);
            w.w11 <= orth_el(w.w11, w.w01, d_q, e_q);
        end else if (en_norm) begin
            w.w00 <= norm_el(w.w00, m0);
            w.w01 <= norm_el(w.w01, m0);
            w.w10 <= norm_el(w.w10, m1);
            w.w11 <= norm_el(w.w11, m1);
        end
    end

endmodule

`default_nettype wire

// File: design/error_unit.sv
`timescale 1ns/1ns
`default_nettype none

module error_unit (
    input  wire                          clk_fastica,
    input  wire                          go_fastica,
    input  wire                          en_error,
    input  wire                          err_clear,
    input  wire fastica_pkg::weight_mat_t w,
    input  wire fastica_pkg::weight_mat_t w_new,
    input  wire                          wnew_valid,
    output logic                         is_converge,
    output fastica_pkg::iter_t            iterations
);
    import fastica_pkg::*;

    acc_t diff_sum;
    logic conv_q;

    // L1 distance between the old and the new W
    assign diff_sum = abs_acc(acc_t'(w_new.w00) - w.w00)
                    + abs_acc(acc_t'(w_new.w01) - w.w01)
                    + abs_acc(acc_t'(w_new.w10) - w.w10)
                    + abs_acc(acc_t'(w_new.w11) - w.w11);

    assign is_converge = conv_q & en_error;

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            conv_q     <= 1'b0;
            iterations <= '0;
        end else if (err_clear) begin
            conv_q     <= 1'b0;
            iterations <= '0;
        end else if (wnew_valid) begin
            iterations <= iterations + 1'b1;
            // the cap also counts as converged
            conv_q     <= conv_q || (diff_sum < err_tol) || (iterations + 1 >= max_iter);
        end
    end

endmodule

`default_nettype wire

// File: design/fast_update.sv
`timescale 1ns/1ns
`default_nettype none

module fast_update (
    input  wire                          clk_fastica,
    input  wire                          go_fastica,
    input  wire                          go_fast,
    input  wire fastica_pkg::weight_mat_t w,
    input  wire fastica_pkg::sample_t     rdata,
    output fastica_pkg::mem_req_t         fu_req,
    output logic                         fast_busy,
    output fastica_pkg::weight_mat_t      w_new,
    output logic                         wnew_valid
);
    import fastica_pkg::*;

    logic            go_fast_d;
    logic            running;
    logic            row;
    logic [n_log2:0] idx;
    logic            rd_q;
    logic            v1;
    coef_t           wa;
    coef_t           wb;
    sample_t         x1;
    acc_t            y1;
    acc_t            cube;
    acc_t            acc0;
    acc_t            acc1;
    coef_t           n00_q;
    coef_t           n01_q;

    function automatic coef_t new_coef(acc_t a, coef_t wv);
        return sat_coef((a >>> 12) - 3 * acc_t'(wv));
    endfunction

    // row index steps 0..17: 16 reads then 2 cycles of pipeline drain
    assign fast_busy = (go_fast & ~go_fast_d) | running;
    assign wa        = row ? w.w10 : w.w00;
    assign wb        = row ? w.w11 : w.w01;
    assign cube      = (y1 * y1 * y1) >>> (2 * frac_bits);

    always_comb begin
        fu_req      = '0;
        fu_req.req  = fast_busy && (idx < n_samples);
        fu_req.addr = addr_t'(idx);
    end

    // row 0 is held, row 1 is read straight off the accumulators
    assign w_new = '{w00: n00_q, w01: n01_q,
                     w10: new_coef(acc0, w.w10), w11: new_coef(acc1, w.w11)};

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            go_fast_d  <= 1'b0;
            running    <= 1'b0;
            row        <= 1'b0;
            idx        <= '0;
            rd_q       <= 1'b0;
            v1         <= 1'b0;
            wnew_valid <= 1'b0;
        end else begin
            go_fast_d  <= go_fast;
            rd_q       <= fu_req.req;
            v1         <= rd_q;
            wnew_valid <= 1'b0;
            if (fast_busy) begin
                if (idx == n_samples + 1) begin
                    idx        <= '0;
                    row        <= ~row;
                    running    <= ~row;
                    wnew_valid <= row;
                end else begin
                    idx     <= idx + 1'b1;
                    running <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_fastica) begin
        // stage 1 projects the returned sample onto the current row
        x1 <= rdata;
        y1 <= dot_q8(wa, wb, rdata);
        if (fast_busy && (idx == '0)) begin
            acc0 <= '0;
            acc1 <= '0;
            if (row) begin
                n00_q <= new_coef(acc0, w.w00);
                n01_q <= new_coef(acc1, w.w01);
            end
        end else if (v1) begin
            // stage 2: x times g(y)
            acc0 <= acc0 + acc_t'(x1.ch0) * cube;
            acc1 <= acc1 + acc_t'(x1.ch1) * cube;
        end
    end

endmodule

`default_nettype wire

// File: design/fastica_controller.sv
`timescale 1ns/1ns
`default_nettype none

module fastica_controller (
    input  wire  clk_fastica,
    input  wire  go_fastica,
    input  wire  start,
    input  wire  symm_busy,
    input  wire  fast_busy,
    input  wire  is_converge,
    output logic fastica_busy,
    output logic go_symm,
    output logic en_norm,
    output logic go_fast,
    output logic en_error,
    output logic err_clear,
    output logic en_mul1,
    output logic en_mem1,
    output logic done
);
    import fastica_pkg::*;

    fsm_state_t state;
    logic [6:0] clk_cnt;

    // per-state enables
    always_comb begin
        go_symm      = 1'b0;
        en_norm      = 1'b0;
        go_fast      = 1'b0;
        en_error     = 1'b0;
        err_clear    = 1'b0;
        en_mul1      = 1'b0;
        en_mem1      = 1'b0;
        done         = 1'b0;
        fastica_busy = !(state inside {init, delay, orth_delay});
        case (state)
            orth_delay: begin
                err_clear = 1'b1;
            end
            make_orth: begin
                go_symm = 1'b1;
            end
            norm_div: begin
                en_norm = 1'b1;
            end
            fast_ica: begin
                go_fast = 1'b1;
            end
            error_delay, error_calc: begin
                en_error = 1'b1;
            end
            mul1: begin
                en_mul1 = 1'b1;
            end
            mem1: begin
                en_mul1 = 1'b1;
                en_mem1 = 1'b1;
                // last cycle of the separation window
                done    = (clk_cnt == sep_cycles - 1);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            state <= init;
        end else begin
            case (state)
                init: begin
                    if (start) begin
                        state <= delay;
                    end
                end
                delay: begin
                    state <= orth_delay;
                end
                orth_delay: begin
                    if (clk_cnt == 7'd4) begin
                        state <= make_orth;
                    end
                end
                make_orth: begin
                    if (!symm_busy && (clk_cnt == 7'd0)) begin
                        state <= norm_div;
                    end
                end
                norm_div: begin
                    state <= fast_ica;
                end
                fast_ica: begin
                    if (!fast_busy && (clk_cnt == 7'd0)) begin
                        state <= error_delay;
                    end
                end
                error_delay: begin
                    state <= error_calc;
                end
                error_calc: begin
                    // counter enters at 1 from error_delay
                    if (is_converge) begin
                        state <= mul1;
                    end else if (clk_cnt == 7'd5) begin
                        state <= make_orth;
                    end
                end
                mul1: begin
                    state <= mem1;
                end
                mem1: begin
                    if (clk_cnt == sep_cycles - 1) begin
                        state <= init;
                    end
                end
                default: begin
                    state <= init;
                end
            endcase
        end
    end

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            clk_cnt <= 7'd0;
        end else begin
            case (state)
                mem1, orth_delay, norm_div, error_delay, error_calc: begin
                    clk_cnt <= clk_cnt + 7'd1;
                end
                default: begin
                    clk_cnt <= 7'd0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/fastica_pkg.sv
`default_nettype none

package fastica_pkg;

    // number format and block geometry
    localparam int frac_bits   = 8;
    localparam int n_samples   = 16;
    localparam int n_log2      = 4;
    localparam int result_base = 16;

    // iteration control
    localparam int err_tol    = 4;
    localparam int max_iter   = 8;
    localparam int sep_cycles = 128;

    typedef logic signed [15:0] coef_t;
    typedef logic        [4:0]  addr_t;
    typedef logic signed [39:0] acc_t;
    typedef logic        [3:0]  iter_t;

    // one store word, either a mixed sample or a separated pair
    typedef struct packed {
        coef_t ch0;
        coef_t ch1;
    } sample_t;

    typedef struct packed {
        coef_t w00;
        coef_t w01;
        coef_t w10;
        coef_t w11;
    } weight_mat_t;

    typedef struct packed {
        logic    req;
        logic    we;
        addr_t   addr;
        sample_t wdata;
    } mem_req_t;

    typedef enum logic [3:0] {
        init,
        delay,
        orth_delay,
        make_orth,
        norm_div,
        fast_ica,
        error_delay,
        error_calc,
        mul1,
        mem1
    } fsm_state_t;

    // clamp a wide intermediate to one Q8.8 word
    function automatic coef_t sat_coef(acc_t v);
        if (v > 32767) begin
            return 16'sh7fff;
        end
        if (v < -32768) begin
            return 16'sh8000;
        end
        return coef_t'(v);
    endfunction

    function automatic acc_t abs_acc(acc_t v);
        return (v < 0) ? -v : v;
    endfunction

    // row of W times a sample, back in Q8.8 scale
    function automatic acc_t dot_q8(coef_t a, coef_t b, sample_t x);
        return (acc_t'(a) * acc_t'(x.ch0) + acc_t'(b) * acc_t'(x.ch1)) >>> frac_bits;
    endfunction

endpackage

`default_nettype wire

// File: design/fastica_top.sv
`timescale 1ns/1ns
`default_nettype none

module fastica_top (
    input  wire                       clk_fastica,
    input  wire                       go_fastica,
    input  wire                       start,
    input  wire fastica_pkg::mem_req_t host_req,
    output fastica_pkg::sample_t       host_rdata,
    output logic                      fastica_busy,
    output logic                      done,
    output fastica_pkg::iter_t         iterations
);
    import fastica_pkg::*;

    logic        symm_busy;
    logic        fast_busy;
    logic        is_converge;
    logic        go_symm;
    logic        en_norm;
    logic        go_fast;
    logic        en_error;
    logic        err_clear;
    logic        en_mul1;
    logic        en_mem1;
    logic        wnew_valid;
    weight_mat_t w;
    weight_mat_t w_new;
    mem_req_t    fu_req;
    mem_req_t    sep_req;

    fastica_controller i_controller (
        .clk_fastica, .go_fastica, .start, .symm_busy, .fast_busy, .is_converge,
        .fastica_busy, .go_symm, .en_norm, .go_fast, .en_error, .err_clear,
        .en_mul1, .en_mem1, .done
    );

    // the store's read bus is shared by the engines and the host
    sample_store i_store (
        .clk_fastica, .fu_req, .sep_req, .host_req, .rdata(host_rdata)
    );

    decor_unit i_decor (
        .clk_fastica, .go_fastica, .start, .go_symm, .en_norm, .w_new, .wnew_valid,
        .w, .symm_busy
    );

    fast_update i_fast_update (
        .clk_fastica, .go_fastica, .go_fast, .w, .rdata(host_rdata),
        .fu_req, .fast_busy, .w_new, .wnew_valid
    );

    error_unit i_error (
        .clk_fastica, .go_fastica, .en_error, .err_clear, .w, .w_new, .wnew_valid,
        .is_converge, .iterations
    );

    sep_unit i_sep (
        .clk_fastica, .go_fastica, .en_mul1, .en_mem1, .w, .rdata(host_rdata), .sep_req
    );

endmodule

`default_nettype wire

// File: design/sample_store.sv
`timescale 1ns/1ns
`default_nettype none

module sample_store (
    input  wire                       clk_fastica,
    input  wire fastica_pkg::mem_req_t fu_req,
    input  wire fastica_pkg::mem_req_t sep_req,
    input  wire fastica_pkg::mem_req_t host_req,
    output fastica_pkg::sample_t       rdata
);
    import fastica_pkg::*;

    // samples at 0..15, separated results at 16..31
    sample_t  mem [2**$bits(addr_t)];
    mem_req_t grant;

    // fixed priority, losers are dropped
    always_comb begin
        if (fu_req.req) begin
            grant = fu_req;
        end else if (sep_req.req) begin
            grant = sep_req;
        end else begin
            grant = host_req;
        end
    end

    always_ff @(posedge clk_fastica) begin
        if (grant.req && grant.we) begin
            mem[grant.addr] <= grant.wdata;
        end
        rdata <= mem[grant.addr];
    end

endmodule

`default_nettype wire

// File: design/sep_unit.sv
`timescale 1ns/1ns
`default_nettype none

module sep_unit (
    input  wire                          clk_fastica,
    input  wire                          go_fastica,
    input  wire                          en_mul1,
    input  wire                          en_mem1,
    input  wire fastica_pkg::weight_mat_t w,
    input  wire fastica_pkg::sample_t     rdata,
    output fastica_pkg::mem_req_t         sep_req
);
    import fastica_pkg::*;

    logic [1:0]      ph;
    logic [n_log2:0] n;
    weight_mat_t     wl;
    sample_t         res_q;

    // per sample: read, compute, write back
    always_comb begin
        sep_req = '0;
        if (en_mem1 && !n[n_log2]) begin
            if (ph == 2'd0) begin
                sep_req.req  = 1'b1;
                sep_req.addr = addr_t'(n);
            end else if (ph == 2'd2) begin
                sep_req.req   = 1'b1;
                sep_req.we    = 1'b1;
                sep_req.addr  = addr_t'(result_base + n);
                sep_req.wdata = res_q;
            end
        end
    end

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            ph <= 2'd0;
            n  <= '0;
        end else if (!en_mem1) begin
            ph <= 2'd0;
            n  <= '0;
        end else if (!n[n_log2]) begin
            // idle once all samples are written
            ph <= (ph == 2'd2) ? 2'd0 : ph + 2'd1;
            if (ph == 2'd2) begin
                n <= n + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_fastica) begin
        if (en_mul1 && !en_mem1) begin
            wl <= w;
        end
        if (ph == 2'd1) begin
            res_q.ch0 <= sat_coef(dot_q8(wl.w00, wl.w01, rdata));
            res_q.ch1 <= sat_coef(dot_q8(wl.w10, wl.w11, rdata));
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_fastica -o tb_fastica_sim

out=$(./obj_dir/tb_fastica_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// File: sim/clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clk_gen (
    output logic clk_fastica,
    output logic go_fastica
);
    localparam int half_period = 2;
    localparam int reset_cycles = 4;

    initial begin
        clk_fastica = 1'b0;
        forever begin
            #half_period clk_fastica = ~clk_fastica;
        end
    end

    // reset held low for the first few edges
    initial begin
        go_fastica = 1'b0;
        repeat (reset_cycles) @(posedge clk_fastica);
        go_fastica <= 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/fastica_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module fastica_assertions (
    input wire                        clk_fastica,
    input wire                        go_fastica,
    input wire                        done,
    input wire                        fastica_busy,
    input wire                        symm_busy,
    input wire fastica_pkg::mem_req_t fu_req,
    input wire fastica_pkg::mem_req_t sep_req,
    input wire fastica_pkg::mem_req_t host_req
);
    logic [2:0] writers;

    assign writers = {fu_req.req & fu_req.we, sep_req.req & sep_req.we,
                      host_req.req & host_req.we};

    a_one_writer: assert property (@(posedge clk_fastica) disable iff (!go_fastica)
        $onehot0(writers))
        else $error("more than one store peer writes in one cycle");

    a_done_pulse: assert property (@(posedge clk_fastica) disable iff (!go_fastica)
        done |=> !done)
        else $error("done lasts longer than one cycle");

    a_idle_after_done: assert property (@(posedge clk_fastica) disable iff (!go_fastica)
        done |=> !fastica_busy)
        else $error("engine still busy after done");

    a_symm_len: assert property (@(posedge clk_fastica) disable iff (!go_fastica)
        $rose(symm_busy) |=> symm_busy ##1 !symm_busy)
        else $error("orthogonalization busy window is not two cycles");

endmodule

bind fastica_top fastica_assertions i_assertions (.*);

`default_nettype wire

// File: sim/tb_fastica.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fastica;
    import fastica_pkg::*;

    localparam int run_cycles = 700;
    localparam int load_cycles = 4 * n_samples * 2;
    localparam longint watchdog_ns = 2 * 3 * (run_cycles + load_cycles) * 4;

    logic     clk_fastica;
    logic     go_fastica;
    logic     start;
    mem_req_t host_req;
    sample_t  host_rdata;
    logic     fastica_busy;
    logic     done;
    iter_t    iterations;

    integer   seed;
    sample_t  blk [n_samples];
    sample_t  exp_res [n_samples];
    sample_t  got_res [n_samples];
    int       exp_iter;
    int       got_iter;
    event     results_ready;
    event     cmp_done;

    clk_gen i_clk_gen (.clk_fastica, .go_fastica);

    fastica_top i_fastica_top (
        .clk_fastica, .go_fastica, .start, .host_req, .host_rdata,
        .fastica_busy, .done, .iterations
    );

    function automatic longint sat16(longint v);
        if (v > 32767) begin
            return 32767;
        end
        if (v < -32768) begin
            return -32768;
        end
        return v;
    endfunction

    function automatic longint mag(longint v);
        return (v < 0) ? -v : v;
    endfunction

    // golden FastICA loop on a whitened two-channel block
    function automatic int ref_model(input sample_t xs [n_samples],
                                     output sample_t res [n_samples]);
        longint w [4];
        longint nw [4];
        longint d, e, m, y, c, acc0, acc1, sum, x0, x1;
        int     it;
        int     r, k, n;
        bit     conv;
        w = '{256, 0, 0, 256};
        it = 0;
        conv = 0;
        while (!conv) begin
            d = w[0] * w[2] + w[1] * w[3];
            e = w[0] * w[0] + w[1] * w[1];
            if (e != 0) begin
                w[2] = sat16(w[2] - (d * w[0]) / e);
                w[3] = sat16(w[3] - (d * w[1]) / e);
            end
            for (r = 0; r < 2; r++) begin
                m = (mag(w[2*r]) > mag(w[2*r+1])) ? mag(w[2*r]) : mag(w[2*r+1]);
                if (m != 0) begin
                    for (k = 0; k < 2; k++) begin
                        w[2*r+k] = sat16((w[2*r+k] <<< 8) / m);
                    end
                end
            end
            for (r = 0; r < 2; r++) begin
                acc0 = 0;
                acc1 = 0;
                for (n = 0; n < n_samples; n++) begin
                    x0 = longint'(xs[n].ch0);
                    x1 = longint'(xs[n].ch1);
                    y = (w[2*r] * x0 + w[2*r+1] * x1) >>> 8;
                    c = (y * y * y) >>> 16;
                    acc0 += x0 * c;
                    acc1 += x1 * c;
                end
                nw[2*r] = sat16((acc0 >>> 12) - 3 * w[2*r]);
                nw[2*r+1] = sat16((acc1 >>> 12) - 3 * w[2*r+1]);
            end
            sum = 0;
            for (k = 0; k < 4; k++) begin
                sum += mag(nw[k] - w[k]);
            end
            it++;
            conv = (sum < err_tol) || (it >= max_iter);
            w = nw;
        end
        for (n = 0; n < n_samples; n++) begin
            x0 = longint'(xs[n].ch0);
            x1 = longint'(xs[n].ch1);
            res[n].ch0 = coef_t'(sat16((w[0] * x0 + w[1] * x1) >>> 8));
            res[n].ch1 = coef_t'(sat16((w[2] * x0 + w[3] * x1) >>> 8));
        end
        return it;
    endfunction

    task automatic check(input string name, input longint got, input longint expected);
        if (got !== expected) begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, expected);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic host_write(input int addr, input sample_t data);
        @(posedge clk_fastica);
        host_req <= '{req: 1'b1, we: 1'b1, addr: addr_t'(addr), wdata: data};
        @(posedge clk_fastica);
        host_req <= '0;
    endtask

    // one cycle read latency, sampled away from the edge
    task automatic host_read(input int addr, output sample_t data);
        @(posedge clk_fastica);
        host_req <= '{req: 1'b1, we: 1'b0, addr: addr_t'(addr), wdata: '0};
        @(posedge clk_fastica);
        host_req <= '0;
        @(negedge clk_fastica);
        data = host_rdata;
    endtask

    task automatic run_block();
        sample_t rd;
        int      n;
        int      cyc;
        for (n = 0; n < n_samples; n++) begin
            host_write(n, blk[n]);
        end
        for (n = 0; n < n_samples; n++) begin
            host_read(n, rd);
            check($sformatf("host_rdata[%0d]", n), rd, blk[n]);
            check("fastica_busy", fastica_busy, 0);
            check("done", done, 0);
        end
        exp_iter = ref_model(blk, exp_res);
        @(posedge clk_fastica);
        start <= 1'b1;
        @(posedge clk_fastica);
        start <= 1'b0;
        cyc = 0;
        do begin
            @(negedge clk_fastica);
            cyc++;
            check("done", done, 0);
        end while (!fastica_busy && cyc < 8);
        check("fastica_busy", fastica_busy, 1);
        check("busy_latency_ok", cyc <= 7, 1);
        cyc = 0;
        while (!done) begin
            @(negedge clk_fastica);
            cyc++;
            if (cyc > run_cycles) begin
                $display("engine never signalled done after start");
                $display("SIMULATION FAILED");
                $fatal(1);
            end
            check("fastica_busy", fastica_busy, 1);
        end
        got_iter = int'(iterations);
        @(negedge clk_fastica);
        check("fastica_busy", fastica_busy, 0);
        for (n = 0; n < n_samples; n++) begin
            host_read(result_base + n, got_res[n]);
        end
        ->results_ready;
        @(cmp_done);
    endtask

    initial begin : compare
        int n;
        forever begin
            @(results_ready);
            for (n = 0; n < n_samples; n++) begin
                check($sformatf("result[%0d].ch0", n), got_res[n].ch0, exp_res[n].ch0);
                check($sformatf("result[%0d].ch1", n), got_res[n].ch1, exp_res[n].ch1);
            end
            check("iterations_in_range", (got_iter >= 1) && (got_iter <= max_iter), 1);
            check("iterations", got_iter, exp_iter);
            ->cmp_done;
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("run did not finish in time, the engine appears to hang");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    initial begin : stimulus
        int n;
        seed = 32'h95b3_b182;
        start = 1'b0;
        host_req = '0;
        @(posedge go_fastica);
        repeat (2) @(posedge clk_fastica);

        // random block
        for (n = 0; n < n_samples; n++) begin
            blk[n].ch0 = coef_t'($random(seed) % 513);
            blk[n].ch1 = coef_t'($random(seed) % 513);
        end
        run_block();

        // channel 1 silent
        for (n = 0; n < n_samples; n++) begin
            blk[n].ch0 = coef_t'($random(seed) % 513);
            blk[n].ch1 = '0;
        end
        run_block();

        // fresh data, no reset in between
        for (n = 0; n < n_samples; n++) begin
            blk[n].ch0 = coef_t'($random(seed) % 513);
            blk[n].ch1 = coef_t'($random(seed) % 513);
        end
        run_block();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/fastica_pkg.sv
design/fastica_controller.sv
design/sample_store.sv
design/decor_unit.sv
design/fast_update.sv
design/error_unit.sv
design/sep_unit.sv
design/fastica_top.sv
sim/clk_gen.sv
sim/fastica_assertions.sv
sim/tb_fastica.sv
